// File: build.f
rtl/bip_mem_pkg.sv
rtl/bip_isa_pkg.sv
rtl/bip_data_mem.sv
rtl/bip_prog_mem.sv
rtl/bip_control.sv
rtl/bip_datapath.sv
rtl/bip_top.sv
test/tb_clock_gen.sv
test/tb_bip_top.sv

// File: rtl/bip_control.sv
`default_nettype none

module bip_control (
  input  logic                              i_clk,       // Core clock
  input  logic                              i_rst,       // Sync reset
  input  bip_isa_pkg::bip_instr_t           i_instr,     // Fetched word
  output bip_mem_pkg::pmem_addr_t           o_pc,        // Fetch address
  output bip_isa_pkg::bip_ctrl_t            o_ctrl,      // Decoded control word
  output logic [bip_isa_pkg::OPERAND_W-1:0] o_operand,   // Address or immediate
  output logic                              o_halt       // Sticky stop flag
);
  import bip_isa_pkg::*;
  import bip_mem_pkg::*;

  typedef enum logic {
    RUN,
    HALTED
  } state_e;

  state_e     state_q;   // Run or halted
  pmem_addr_t pc_q;      // Program counter
  opcode_e    opcode;    // Current opcode
  logic       is_hlt;    // HLT in fetch register
  bip_ctrl_t  ctrl;      // Decoder output

  assign opcode    = i_instr.opcode;
  assign o_operand = i_instr.operand;
  assign is_hlt    = (opcode == OP_HLT);

  // PC and run state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= RUN;
      pc_q    <= '0;
    end else if (state_q == RUN) begin
      if (is_hlt) begin
        state_q <= HALTED;      // PC stays on the HLT
      end else begin
        pc_q <= pc_q + 1'b1;    // One instruction per clock
      end
    end
  end

  // Instruction decoder
  always_comb begin
    ctrl.wr_acc = 1'b0;
    ctrl.sel_a  = SEL_A_ALU;
    ctrl.sel_b  = SEL_B_MEM;
    ctrl.alu_op = ALU_ADD;
    ctrl.wr_ram = 1'b0;
    ctrl.rd_ram = 1'b0;
    case (opcode)
      OP_STO: begin
        ctrl.wr_ram = 1'b1;                // Acc to memory
      end
      OP_LD: begin
        ctrl.rd_ram = 1'b1;
        ctrl.wr_acc = 1'b1;
        ctrl.sel_a  = SEL_A_MEM;           // Memory word straight in
      end
      OP_LDI: begin
        ctrl.wr_acc = 1'b1;
        ctrl.sel_a  = SEL_A_IMM;
      end
      OP_ADD, OP_SUB: begin
        ctrl.rd_ram = 1'b1;
        ctrl.wr_acc = 1'b1;
        ctrl.sel_b  = SEL_B_MEM;
        ctrl.alu_op = (opcode == OP_SUB) ? ALU_SUB : ALU_ADD;
      end
      OP_ADDI, OP_SUBI: begin
        ctrl.wr_acc = 1'b1;
        ctrl.sel_b  = SEL_B_IMM;
        ctrl.alu_op = (opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
      end
      default: begin
      end                                  // HLT and unused codes do nothing
    endcase
    if (state_q == HALTED) begin
      ctrl.wr_acc = 1'b0;                  // Freeze everything
      ctrl.wr_ram = 1'b0;
      ctrl.rd_ram = 1'b0;
    end
  end

  assign o_ctrl = ctrl;
  assign o_pc   = pc_q;
  assign o_halt = (state_q == HALTED);

  // Halt is sticky until reset
  assert property (@(posedge i_clk) (o_halt && !i_rst) |=> o_halt)
    else $error("o_halt dropped without reset");

endmodule

`default_nettype wire

// File: rtl/bip_data_mem.sv
`default_nettype none

module bip_data_mem (
  input  logic                    i_clk,    // Core clock
  input  logic                    i_rst,    // Clears output register only
  input  bip_mem_pkg::dmem_addr_t i_addr,   // Word address from operand
  input  bip_mem_pkg::word_t      i_data,   // Accumulator value to store
  input  logic                    i_wr,     // Write strobe
  input  logic                    i_rd,     // Read strobe
  output bip_mem_pkg::word_t      o_data    // Registered read word
);
  import bip_mem_pkg::*;

  word_t ram [DMEM_DEPTH] = '{default: '0};   // Inferred block RAM
  word_t ram_data;                            // Read register
  logic  enb;                                 // Port active this edge

  assign enb    = i_wr ^ i_rd;   // One strobe at a time
  assign o_data = ram_data;

  // Falling edge port so the access lands within the instruction cycle
  always_ff @(negedge i_clk) begin
    if (i_rst) begin
      ram_data <= '0;                  // Contents kept
    end else if (enb) begin
      if (i_wr) begin
        ram[i_addr] <= i_data;         // Store
      end else begin
        ram_data <= ram[i_addr];       // Load into read register
      end
    end
  end

  // Decoder never asks for both strobes
  assert property (@(negedge i_clk) !(i_wr && i_rd))
    else $error("data memory write and read strobes high together");

  // Read word holds across idle edges
  assert property (@(negedge i_clk) disable iff (i_rst)
    (!i_wr && !i_rd) |=> $stable(o_data))
    else $error("data memory output changed without a read");

endmodule

`default_nettype wire

// File: rtl/bip_datapath.sv
`default_nettype none

module bip_datapath (
  input  logic                              i_clk,        // Core clock
  input  logic                              i_rst,        // Sync reset
  input  bip_isa_pkg::bip_ctrl_t            i_ctrl,       // From decoder
  input  logic [bip_isa_pkg::OPERAND_W-1:0] i_operand,    // Raw operand field
  input  bip_mem_pkg::word_t                i_mem_data,   // Data memory read word
  output bip_mem_pkg::word_t                o_acc         // Accumulator
);
  import bip_isa_pkg::*;
  import bip_mem_pkg::*;

  bip_ctrl_t            ex_ctrl_q;      // Control of the instruction in execute
  logic [OPERAND_W-1:0] ex_operand_q;   // Its operand
  logic                 rst_q;          // Reset sampled on the last rising edge
  word_t                imm_ext;        // Sign extended immediate
  word_t                alu_b;          // Second ALU operand
  word_t                alu_res;        // Add or subtract result
  word_t                acc_d;          // Next accumulator value
  word_t                acc_q;          // Accumulator register

  always_ff @(posedge i_clk) begin
    rst_q <= i_rst;
  end

  // Capture decode on the same falling edge as the memory access
  // before the fetch register moves to the next instruction
  always_ff @(negedge i_clk) begin
    if (i_rst || rst_q) begin
      ex_ctrl_q <= '0;            // Word fetched under reset runs one edge later
    end else begin
      ex_ctrl_q <= i_ctrl;
    end
  end

  always_ff @(negedge i_clk) begin
    ex_operand_q <= i_operand;
  end

  assign imm_ext = {{(DATA_WIDTH-OPERAND_W){ex_operand_q[OPERAND_W-1]}}, ex_operand_q};

  assign alu_b = (ex_ctrl_q.sel_b == SEL_B_IMM) ? imm_ext : i_mem_data;

  // Wraps modulo 2^16
  assign alu_res = (ex_ctrl_q.alu_op == ALU_SUB) ? (acc_q - alu_b) : (acc_q + alu_b);

  always_comb begin
    case (ex_ctrl_q.sel_a)
      SEL_A_MEM: acc_d = i_mem_data;   // LD
      SEL_A_IMM: acc_d = imm_ext;      // LDI
      default:   acc_d = alu_res;      // Arithmetic
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      acc_q <= '0;
    end else if (ex_ctrl_q.wr_acc) begin
      acc_q <= acc_d;
    end
  end

  assign o_acc = acc_q;

endmodule

`default_nettype wire

// File: rtl/bip_isa_pkg.sv
`default_nettype none

package bip_isa_pkg;

  localparam int OPCODE_W  = 5;    // Upper field of the instruction
  localparam int OPERAND_W = 11;   // Address or signed immediate

  // Opcode encoding 0 to 7
  typedef enum logic [OPCODE_W-1:0] {
    OP_HLT  = 5'd0,   // Stop and hold state
    OP_STO  = 5'd1,   // mem[op] = acc
    OP_LD   = 5'd2,   // acc = mem[op]
    OP_LDI  = 5'd3,   // acc = sext(op)
    OP_ADD  = 5'd4,   // acc += mem[op]
    OP_ADDI = 5'd5,   // acc += sext(op)
    OP_SUB  = 5'd6,   // acc -= mem[op]
    OP_SUBI = 5'd7    // acc -= sext(op)
  } opcode_e;

  typedef struct packed {
    opcode_e                opcode;    // Bits 15..11
    logic [OPERAND_W-1:0]   operand;   // Bits 10..0
  } bip_instr_t;

  typedef enum logic [1:0] {
    SEL_A_MEM,   // Memory word
    SEL_A_IMM,   // Extended immediate
    SEL_A_ALU    // Adder output
  } sel_a_e;

  typedef enum logic {
    SEL_B_MEM,   // Memory word
    SEL_B_IMM    // Extended immediate
  } sel_b_e;

  typedef enum logic {
    ALU_ADD,
    ALU_SUB
  } alu_op_e;

  // Control word, 7 bits
  typedef struct packed {
    logic    wr_acc;   // Load accumulator
    sel_a_e  sel_a;    // Accumulator source
    sel_b_e  sel_b;    // ALU operand B source
    alu_op_e alu_op;   // Add or subtract
    logic    wr_ram;   // Data memory write strobe
    logic    rd_ram;   // Data memory read strobe
  } bip_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/bip_mem_pkg.sv
`default_nettype none

package bip_mem_pkg;

  // Memory geometry
  localparam int DATA_WIDTH  = 16;                   // Accumulator and memory word
  localparam int DMEM_DEPTH  = 1024;                 // Data words
  localparam int PMEM_DEPTH  = 2048;                 // Instruction words
  localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);   // 10 bits
  localparam int PMEM_ADDR_W = $clog2(PMEM_DEPTH);   // 11 bits

  typedef logic [DATA_WIDTH-1:0]  word_t;            // Data word
  typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;       // Data memory address
  typedef logic [PMEM_ADDR_W-1:0] pmem_addr_t;       // Program counter width

endpackage

`default_nettype wire

// File: rtl/bip_prog_mem.sv
`default_nettype none

module bip_prog_mem (
  input  logic                    i_clk,     // Core clock
  input  logic                    i_we,      // Load strobe
  input  bip_mem_pkg::pmem_addr_t i_waddr,   // Load address
  input  bip_isa_pkg::bip_instr_t i_wdata,   // Load word
  input  bip_mem_pkg::pmem_addr_t i_raddr,   // Fetch address from PC
  output bip_isa_pkg::bip_instr_t o_instr    // Fetched instruction
);
  import bip_mem_pkg::*;
  import bip_isa_pkg::*;

  bip_instr_t mem [PMEM_DEPTH] = '{default: '0};   // Instruction store
  bip_instr_t instr_q;                             // Fetch register

  // Load port on the rising edge
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Fetch half a cycle after PC update
  always_ff @(negedge i_clk) begin
    instr_q <= mem[i_raddr];   // Settles before the data memory edge after it
  end

  assign o_instr = instr_q;

endmodule

`default_nettype wire

// File: rtl/bip_top.sv
`default_nettype none

module bip_top (
  input  logic                    i_clk,         // Core clock
  input  logic                    i_rst,         // Sync reset, program loads meanwhile
  input  logic                    i_prog_we,     // Program load strobe
  input  bip_mem_pkg::pmem_addr_t i_prog_addr,   // Program load address
  input  bip_isa_pkg::bip_instr_t i_prog_data,   // Program load word
  output bip_mem_pkg::word_t      o_acc,         // Accumulator
  output bip_mem_pkg::pmem_addr_t o_pc,          // Program counter
  output logic                    o_halt         // Program finished
);
  import bip_isa_pkg::*;
  import bip_mem_pkg::*;

  bip_instr_t           instr;        // Fetch register
  bip_ctrl_t            ctrl;         // Control word
  logic [OPERAND_W-1:0] operand;      // Operand field
  dmem_addr_t           dmem_addr;    // Low operand bits
  word_t                dmem_rdata;   // Data memory read word

  assign dmem_addr = operand[DMEM_ADDR_W-1:0];

  bip_prog_mem u_prog_mem (
    .i_clk   (i_clk),
    .i_we    (i_prog_we),
    .i_waddr (i_prog_addr),
    .i_wdata (i_prog_data),
    .i_raddr (o_pc),
    .o_instr (instr)
  );

  bip_control u_control (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_instr   (instr),
    .o_pc      (o_pc),
    .o_ctrl    (ctrl),
    .o_operand (operand),
    .o_halt    (o_halt)
  );

  bip_datapath u_datapath (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ctrl     (ctrl),
    .i_operand  (operand),
    .i_mem_data (dmem_rdata),
    .o_acc      (o_acc)
  );

  bip_data_mem u_data_mem (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_addr (dmem_addr),
    .i_data (o_acc),          // STO source
    .i_wr   (ctrl.wr_ram),
    .i_rd   (ctrl.rd_ram),
    .o_data (dmem_rdata)
  );

endmodule

`default_nettype wire

// File: test/tb_bip_top.sv
`default_nettype none

module tb_bip_top;
  timeunit 1ns;
  timeprecision 100ps;
  import bip_mem_pkg::*;
  import bip_isa_pkg::*;

  localparam int SEED             = 32'hf77eb692;
  localparam int CLK_PERIOD_NS    = 4;
  localparam int N_RAND           = 40;    // Random programs
  localparam int RAND_MAX_LEN     = 24;    // Upper bound of words per random program
  localparam int RAND_BASE        = 300;   // Data window of random programs
  localparam int N_DIRECTED_RUNS  = 13;
  localparam int DIRECTED_MAX_LEN = 64;
  localparam int RUN_MARGIN       = 40;    // Load overhead, halt hold, slack
  localparam int WATCHDOG_CYCLES  = N_DIRECTED_RUNS * (2 * DIRECTED_MAX_LEN + RUN_MARGIN)
                                  + N_RAND * (2 * RAND_MAX_LEN + RUN_MARGIN);

  logic       clk;
  logic       rst;
  logic       rst_req;     // Held high while a program loads
  logic       prog_we;
  pmem_addr_t prog_addr;
  bip_instr_t prog_data;
  word_t      acc;
  pmem_addr_t pc;
  logic       halt;

  bip_instr_t prog [$];                  // Program of the current run
  word_t      model_mem [DMEM_DEPTH];    // Shadow data memory kept across runs
  bit         model_known [DMEM_DEPTH];  // Words written in this simulation
  word_t      exp_acc;
  int         exp_pc;                    // Address of the HLT
  int         err_count    = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;

  tb_clock_gen u_clock_gen (
    .i_rst_req (rst_req),
    .o_clk     (clk),
    .o_rst     (rst)
  );

  bip_top UUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_prog_we   (prog_we),
    .i_prog_addr (prog_addr),
    .i_prog_data (prog_data),
    .o_acc       (acc),
    .o_pc        (pc),
    .o_halt      (halt)
  );

  function automatic bip_instr_t make_instr(input opcode_e op, input int operand);
    bip_instr_t w;
    w.opcode  = op;
    w.operand = operand[OPERAND_W-1:0];   // Negative values keep their 11-bit form
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // ISA rules applied in order up to the first HLT
  task automatic model_run();
    word_t      imm;
    dmem_addr_t addr;
    exp_acc = '0;                                 // Accumulator after reset
    exp_pc  = -1;
    for (int i = 0; i < prog.size() && exp_pc < 0; i++) begin
      imm  = {{(DATA_WIDTH-OPERAND_W){prog[i].operand[OPERAND_W-1]}}, prog[i].operand};
      addr = prog[i].operand[DMEM_ADDR_W-1:0];    // Top operand bit is no address bit
      case (prog[i].opcode)
        OP_HLT:  exp_pc = i;
        OP_STO: begin
          model_mem[addr]   = exp_acc;
          model_known[addr] = 1'b1;
        end
        OP_LD:   exp_acc = model_mem[addr];
        OP_LDI:  exp_acc = imm;
        OP_ADD:  exp_acc = exp_acc + model_mem[addr];   // Wraps at 16 bits
        OP_ADDI: exp_acc = exp_acc + imm;
        OP_SUB:  exp_acc = exp_acc - model_mem[addr];
        OP_SUBI: exp_acc = exp_acc - imm;
      endcase
    end
  endtask

  task automatic load_program();
    @(posedge clk);
    rst_req <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= pmem_addr_t'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;                              // Last word lands on this edge
  endtask

  task automatic start_program();
    load_program();
    model_run();
    @(posedge clk);
    rst_req <= 1'b0;                              // Last edge with reset seen
  endtask

  // Waits for o_halt and then checks the final state and the halt edge
  task automatic finish_program(input string label);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (halt !== 1'b1) begin
      cycles++;
      @(negedge clk);
    end
    check_value({label, " o_acc"}, acc, exp_acc);
    check_value({label, " o_pc"}, pc, exp_pc);
    check_value({label, " halt edge"}, cycles, exp_pc + 1);   // One edge after HLT
  endtask

  task automatic run_and_check(input string label);
    start_program();
    finish_program(label);
  endtask

  task automatic report_test(input string name, input int err_start);
    if (err_count == err_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, err_count - err_start);
    end
  endtask

  task automatic test_immediates();
    int err_start;
    err_start = err_count;
    prog = '{make_instr(OP_ADDI, -1), make_instr(OP_ADDI, 2), make_instr(OP_HLT, 0)};
    run_and_check("imm wrap up");
    prog = '{make_instr(OP_LDI, 0), make_instr(OP_SUBI, 1), make_instr(OP_SUBI, -1024),
             make_instr(OP_ADDI, 1023), make_instr(OP_HLT, 0)};
    run_and_check("imm wrap down");
    prog = '{make_instr(OP_LDI, 1023), make_instr(OP_ADDI, -1024), make_instr(OP_LDI, -1024),
             make_instr(OP_SUBI, 1023), make_instr(OP_HLT, 0)};
    run_and_check("imm extremes");
    report_test("immediates", err_start);
  endtask

  task automatic test_store_load();
    int err_start;
    err_start = err_count;
    prog = '{make_instr(OP_LDI, 'h123), make_instr(OP_STO, 0), make_instr(OP_LDI, -2),
             make_instr(OP_STO, 1023), make_instr(OP_LDI, 'h2aa), make_instr(OP_STO, 512),
             make_instr(OP_LD, 0), make_instr(OP_HLT, 0)};
    run_and_check("store 0");
    prog = '{make_instr(OP_LD, 1023), make_instr(OP_HLT, 0)};
    run_and_check("load 1023");
    prog = '{make_instr(OP_LD, 512), make_instr(OP_HLT, 0)};
    run_and_check("load 512");
    prog = '{make_instr(OP_LDI, 'h155), make_instr(OP_STO, 'h600),   // Bit 10 set maps to 512
             make_instr(OP_LDI, 0), make_instr(OP_LD, 512), make_instr(OP_HLT, 0)};
    run_and_check("overwrite");
    report_test("store_load", err_start);
  endtask

  task automatic test_mem_arith();
    int err_start;
    err_start = err_count;
    prog.delete();
    prog.push_back(make_instr(OP_LDI, 1023));
    repeat (7) begin
      prog.push_back(make_instr(OP_STO, 20));   // Doubling walks past 0xffff
      prog.push_back(make_instr(OP_ADD, 20));
    end
    prog.push_back(make_instr(OP_HLT, 0));
    run_and_check("overflow");
    prog = '{make_instr(OP_LDI, 5), make_instr(OP_STO, 21), make_instr(OP_LDI, 2),
             make_instr(OP_SUB, 21), make_instr(OP_SUB, 20), make_instr(OP_ADD, 21),
             make_instr(OP_HLT, 0)};
    run_and_check("underflow");
    report_test("mem_arith", err_start);
  endtask

  task automatic test_halt();
    int err_start;
    err_start = err_count;
    prog = '{make_instr(OP_LDI, 171), make_instr(OP_ADDI, 4), make_instr(OP_STO, 30),
             make_instr(OP_ADD, 30), make_instr(OP_HLT, 0),
             make_instr(OP_ADDI, 1), make_instr(OP_STO, 30)};   // Past the HLT
    run_and_check("halt");
    repeat (20) begin
      @(negedge clk);
      check_value("halted o_acc", acc, exp_acc);
      check_value("halted o_pc", pc, exp_pc);
      check_value("halted o_halt", halt, 1);
    end
    report_test("halt", err_start);
  endtask

  task automatic test_random();
    int         err_start;
    int         len;
    opcode_e    opc;
    dmem_addr_t addr;
    int         operand;
    err_start = err_count;
    for (int n = 0; n < N_RAND; n++) begin
      prog.delete();
      len = 4 + ($urandom % (RAND_MAX_LEN - 4));
      prog.push_back(make_instr(OP_LDI, $urandom));   // LDI first sets a known accumulator
      for (int i = 1; i < len - 1; i++) begin
        opc     = opcode_e'(1 + ($urandom % 7));
        operand = $urandom;
        addr    = dmem_addr_t'(RAND_BASE + ($urandom % 8));
        if (opc inside {OP_STO, OP_LD, OP_ADD, OP_SUB}) begin
          if (opc != OP_STO && !model_known[addr]) begin
            opc = OP_STO;                                 // Write before the first read
          end
          operand = {operand[OPERAND_W-1], addr};        // Random spare bit
          if (opc == OP_STO) begin
            model_known[addr] = 1'b1;
          end
        end
        prog.push_back(make_instr(opc, operand));
      end
      prog.push_back(make_instr(OP_HLT, 0));
      run_and_check($sformatf("random %0d", n));
    end
    report_test("random", err_start);
  endtask

  task automatic test_reset_midrun();
    int err_start;
    err_start = err_count;
    prog = '{make_instr(OP_LDI, 'h1c3), make_instr(OP_STO, 200), make_instr(OP_LDI, -16),
             make_instr(OP_STO, 201)};
    repeat (40) prog.push_back(make_instr(OP_ADDI, 3));   // Long tail to interrupt
    prog.push_back(make_instr(OP_HLT, 0));
    start_program();
    while (pc < 12) @(negedge clk);     // Both stores done by now
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_value("reset o_acc", acc, 0);
    check_value("reset o_pc", pc, 0);
    check_value("reset o_halt", halt, 0);
    prog = '{make_instr(OP_LD, 200), make_instr(OP_HLT, 0)};
    run_and_check("after reset 200");
    prog = '{make_instr(OP_LD, 201), make_instr(OP_HLT, 0)};
    run_and_check("after reset 201");
    report_test("reset_midrun", err_start);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout after %0d cycles, o_halt never rose", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_req   = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    @(negedge rst);                     // Power-on reset over
    test_immediates();
    test_store_load();
    test_mem_arith();
    test_halt();
    test_random();
    test_reset_midrun();
    $display("tests passed %0d, tests failed %0d, value mismatches %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  input  logic i_rst_req,   // Reset request from the test sequence
  output logic o_clk,       // Core clock
  output logic o_rst        // Sync reset, active high
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_NS  = 4;
  localparam int RST_CYCLES = 8;   // Power-on reset length

  int   por_cnt = 0;      // Edges seen during power-on reset
  logic por_rst = 1'b1;   // Power-on reset

  initial o_clk = 1'b0;
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

  always @(posedge o_clk) begin
    if (por_cnt < RST_CYCLES - 1) begin
      por_cnt <= por_cnt + 1;
    end else begin
      por_rst <= 1'b0;      // Released on the 8th edge
    end
  end

  assign o_rst = por_rst | i_rst_req;

endmodule

`default_nettype wire
